/* logic/digimax_pkg.sv */
package digimax_pkg;

	// ====================
	// Widths
	// ====================

	localparam int NUM_DAC_CH = 4;
	localparam int DAC_DATA_W = 8;
	localparam int MIX_W      = 16;

	// Left or right level is the sum of two channel bytes
	localparam int LEVEL_W    = DAC_DATA_W + 1;

	// One guard bit above the sample to spot overflow
	localparam int SUM_W      = MIX_W + 1;

	// ====================
	// Mixer constants
	// ====================

	// Two-slope FM compressor, steep below the knee and flat above it
	localparam int COMP_KNEE  = 14044;
	localparam int COMP_GAIN  = 2;
	localparam int COMP_DIV   = 4;
	localparam int COMP_BASE  = COMP_KNEE * COMP_GAIN;

	localparam int DAC_SHIFT  = 6;
	localparam int CASS_LEVEL = 1024;

	// ====================
	// Types
	// ====================

	// I/O window the sampler answers in
	typedef enum logic [1:0] {
		DAC_OFF  = 2'd0,
		DAC_DE00 = 2'd1,
		DAC_DF00 = 2'd2
	} dac_mode_t;

	// CPU side of the cartridge I/O bus
	typedef struct packed {
		logic                  ioe;
		logic                  iof;
		logic                  wr;
		logic [2:0]            addr;
		logic [DAC_DATA_W-1:0] data;
	} io_bus_t;

	// One write request towards a channel register
	typedef struct packed {
		logic                  en;
		logic [DAC_DATA_W-1:0] data;
	} dac_write_t;

endpackage

/* logic/io_strobe.sv */
`timescale 1ns/1ps

module io_strobe import digimax_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        reset_n,
	input  io_bus_t                     bus_i,
	input  dac_mode_t                   mode_i,
	output dac_write_t [NUM_DAC_CH-1:0] ch_wr_o,
	output logic                        clear_o
);

	logic                        ioe_q;
	logic                        iof_q;
	logic                        sel;
	logic                        sel_prev;
	logic                        wr_hit;
	logic                        clear_q;
	dac_write_t [NUM_DAC_CH-1:0] ch_wr_q;

	// Pick the select of the configured window
	always_comb begin
		case (mode_i)
			DAC_DE00: begin
				sel      = bus_i.ioe;
				sel_prev = ioe_q;
			end
			DAC_DF00: begin
				sel      = bus_i.iof;
				sel_prev = iof_q;
			end
			default: begin
				sel      = 1'b0;
				sel_prev = 1'b0;
			end
		endcase
	end

	// Rising select with write, lower four registers only
	assign wr_hit = sel & ~sel_prev & bus_i.wr & ~bus_i.addr[2];

	// ====================
	// Select history
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			ioe_q   <= 1'b0;
			iof_q   <= 1'b0;
			clear_q <= 1'b0;
		end else begin
			ioe_q   <= bus_i.ioe;
			iof_q   <= bus_i.iof;
			clear_q <= (mode_i == DAC_OFF);
		end
	end

	// One-cycle request to the addressed channel
	always_ff @(posedge clk_sys) begin
		for (int i = 0; i < NUM_DAC_CH; i++) begin
			if (!reset_n) begin
				ch_wr_q[i].en <= 1'b0;
			end else begin
				ch_wr_q[i].en <= wr_hit && (bus_i.addr[1:0] == 2'(i));
			end
			ch_wr_q[i].data <= bus_i.data;
		end
	end

	assign ch_wr_o = ch_wr_q;
	assign clear_o = clear_q;

endmodule

/* logic/dac_channel.sv */
`timescale 1ns/1ps

module dac_channel import digimax_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  clear_i,
	input  dac_write_t            wr_i,
	output logic [DAC_DATA_W-1:0] level_o,
	output logic                  active_o
);

	logic [DAC_DATA_W-1:0] level_q;
	logic                  active_q;

	// Channel byte and sticky activity flag
	always_ff @(posedge clk_sys) begin
		if (!reset_n || clear_i) begin
			level_q  <= '0;
			active_q <= 1'b0;
		end else if (wr_i.en) begin
			level_q <= wr_i.data;
			// Any non-zero byte marks the channel as in use
			if (|wr_i.data) begin
				active_q <= 1'b1;
			end
		end
	end

	assign level_o  = level_q;
	assign active_o = active_q;

endmodule

/* logic/fm_compressor.sv */
`timescale 1ns/1ps

module fm_compressor import digimax_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset_n,
	input  logic signed [MIX_W-1:0] sample_i,
	output logic signed [MIX_W-1:0] sample_o
);

	logic signed [MIX_W-1:0] att_q;
	logic signed [MIX_W-1:0] cmp_q;
	logic        [MIX_W-1:0] mag;
	logic        [MIX_W-1:0] shaped;

	// ====================
	// Stage 1
	// ====================

	// Attenuate by one eighth, x - x/8
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			att_q <= '0;
		end else begin
			att_q <= sample_i - (sample_i >>> 3);
		end
	end

	// ====================
	// Stage 2
	// ====================

	// Work on the magnitude, sign goes back on afterwards
	always_comb begin
		mag = att_q[MIX_W-1] ? $unsigned(-att_q) : $unsigned(att_q);
		if (mag < MIX_W'(COMP_KNEE)) begin
			shaped = mag * MIX_W'(COMP_GAIN);
		end else begin
			// Flat slope above the knee keeps peaks under full scale
			shaped = (mag - MIX_W'(COMP_KNEE)) / MIX_W'(COMP_DIV) + MIX_W'(COMP_BASE);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			cmp_q <= '0;
		end else if (att_q[MIX_W-1]) begin
			cmp_q <= -$signed(shaped);
		end else begin
			cmp_q <= $signed(shaped);
		end
	end

	assign sample_o = cmp_q;

endmodule

/* logic/stereo_mixer.sv */
`timescale 1ns/1ps

module stereo_mixer import digimax_pkg::*; (
	input  logic                                  clk_sys,
	input  logic                                  reset_n,
	input  logic [NUM_DAC_CH-1:0][DAC_DATA_W-1:0] level_i,
	input  logic [NUM_DAC_CH-1:0]                 active_i,
	input  logic signed [MIX_W-1:0]               fm_i,
	input  logic                                  cass_i,
	output logic signed [MIX_W-1:0]               audio_l_o,
	output logic signed [MIX_W-1:0]               audio_r_o
);

	logic        [LEVEL_W-1:0] dac_l_q;
	logic        [LEVEL_W-1:0] dac_r_q;
	logic signed [SUM_W-1:0]   sum_l_q;
	logic signed [SUM_W-1:0]   sum_r_q;
	logic signed [MIX_W-1:0]   out_l_q;
	logic signed [MIX_W-1:0]   out_r_q;

	// FM, scaled DAC level and cassette click in one side
	function automatic logic signed [SUM_W-1:0] mix_side(
		input logic signed [MIX_W-1:0] fm,
		input logic        [LEVEL_W-1:0] dac,
		input logic                      cass
	);
		logic signed [SUM_W-1:0] fm_ext;
		logic signed [SUM_W-1:0] dac_ext;
		logic signed [SUM_W-1:0] cass_ext;

		fm_ext   = {fm[MIX_W-1], fm};
		dac_ext  = $signed(SUM_W'(dac) << DAC_SHIFT);
		cass_ext = cass ? SUM_W'(CASS_LEVEL) : '0;
		return fm_ext + dac_ext + cass_ext;
	endfunction

	// Clip to full scale when the guard bit disagrees with the sign
	function automatic logic signed [MIX_W-1:0] saturate(
		input logic signed [SUM_W-1:0] sum
	);
		if (sum[SUM_W-1] != sum[SUM_W-2]) begin
			return {sum[SUM_W-1], {(MIX_W-1){~sum[SUM_W-1]}}};
		end
		return sum[MIX_W-1:0];
	endfunction

	// ====================
	// Mode guess
	// ====================

	// Mono, stereo on channels 0/1, or four channels paired 1+2 / 0+3
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			dac_l_q <= '0;
			dac_r_q <= '0;
		end else if (active_i < 2) begin
			dac_l_q <= LEVEL_W'(level_i[0]) + LEVEL_W'(level_i[0]);
			dac_r_q <= LEVEL_W'(level_i[0]) + LEVEL_W'(level_i[0]);
		end else if (active_i == 2) begin
			dac_l_q <= LEVEL_W'(level_i[1]) + LEVEL_W'(level_i[1]);
			dac_r_q <= LEVEL_W'(level_i[0]) + LEVEL_W'(level_i[0]);
		end else begin
			dac_l_q <= LEVEL_W'(level_i[1]) + LEVEL_W'(level_i[2]);
			dac_r_q <= LEVEL_W'(level_i[0]) + LEVEL_W'(level_i[3]);
		end
	end

	// ====================
	// Sum and clip
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			sum_l_q <= '0;
			sum_r_q <= '0;
			out_l_q <= '0;
			out_r_q <= '0;
		end else begin
			sum_l_q <= mix_side(fm_i, dac_l_q, cass_i);
			sum_r_q <= mix_side(fm_i, dac_r_q, cass_i);
			out_l_q <= saturate(sum_l_q);
			out_r_q <= saturate(sum_r_q);
		end
	end

	assign audio_l_o = out_l_q;
	assign audio_r_o = out_r_q;

endmodule

/* logic/digimax_audio_top.sv */
`timescale 1ns/1ps

module digimax_audio_top import digimax_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset_n,
	input  io_bus_t                 bus_i,
	input  dac_mode_t               mode_i,
	input  logic signed [MIX_W-1:0] fm_sample_i,
	input  logic                    cass_i,
	output logic signed [MIX_W-1:0] audio_l_o,
	output logic signed [MIX_W-1:0] audio_r_o
);

	dac_write_t [NUM_DAC_CH-1:0]             ch_wr;
	logic                                  clear;
	logic [NUM_DAC_CH-1:0][DAC_DATA_W-1:0] level;
	logic [NUM_DAC_CH-1:0]                 active;
	logic signed [MIX_W-1:0]               fm_cmp;

	// ====================
	// Bus side
	// ====================
	io_strobe io_strobe_inst (
		.clk_sys (clk_sys),
		.reset_n (reset_n),
		.bus_i   (bus_i),
		.mode_i  (mode_i),
		.ch_wr_o (ch_wr),
		.clear_o (clear)
	);

	// Four sampler channels
	for (genvar i = 0; i < NUM_DAC_CH; i++) begin : g_ch
		dac_channel dac_channel_inst (
			.clk_sys  (clk_sys),
			.reset_n  (reset_n),
			.clear_i  (clear),
			.wr_i     (ch_wr[i]),
			.level_o  (level[i]),
			.active_o (active[i])
		);
	end

	// ====================
	// Audio side
	// ====================
	fm_compressor fm_compressor_inst (
		.clk_sys  (clk_sys),
		.reset_n  (reset_n),
		.sample_i (fm_sample_i),
		.sample_o (fm_cmp)
	);

	stereo_mixer stereo_mixer_inst (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.level_i   (level),
		.active_i  (active),
		.fm_i      (fm_cmp),
		.cass_i    (cass_i),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

endmodule

/* verif/digimax_tests.svh */
// ====================
// Directed tests
// ====================

task automatic test_reset_silence();
	int errs;

	errs = error_count;
	set_mode(DAC_OFF);
	fm_sample_i = '0;
	cass_i      = 1'b0;
	settle();
	compare_pair(16'sd0, 16'sd0);
	// Writes are ignored while the sampler is off
	bus_write(1'b0, 3'd0, 8'hff);
	bus_write(1'b1, 3'd1, 8'h80);
	settle();
	compare_pair(16'sd0, 16'sd0);
	check_outputs();
	finish_test("reset_silence", errs);
endtask

task automatic test_mono_guess();
	int                    errs;
	int                    expected;
	logic [DAC_DATA_W-1:0] b;

	errs = error_count;
	set_mode(DAC_DE00);
	settle();
	b = DAC_DATA_W'(random_bits(DAC_DATA_W));
	bus_write(1'b0, 3'd0, b);
	settle();
	expected = 2 * int'(b) * (2 ** DAC_SHIFT);
	compare_pair(MIX_W'(expected), MIX_W'(expected));
	check_outputs();
	// Upper address half holds no channel
	for (int a = 4; a < 8; a++) begin
		bus_write(1'b0, 3'(a), DAC_DATA_W'(random_bits(DAC_DATA_W)));
	end
	// DF00 window is not selected
	bus_write(1'b1, 3'd0, nonzero_byte());
	bus_write(1'b1, 3'd2, nonzero_byte());
	settle();
	compare_pair(MIX_W'(expected), MIX_W'(expected));
	check_outputs();
	finish_test("mono_guess", errs);
endtask

task automatic test_stereo_guess();
	int                    errs;
	int                    exp_l;
	int                    exp_r;
	logic [DAC_DATA_W-1:0] b1;
	logic [DAC_DATA_W-1:0] bytes [NUM_DAC_CH];

	errs = error_count;
	set_mode(DAC_OFF);
	settle();
	set_mode(DAC_DF00);
	settle();

	// Only channel 1 active, left from channel 1 and right from channel 0
	b1 = nonzero_byte();
	bus_write(1'b1, 3'd1, b1);
	settle();
	exp_l = 2 * int'(b1) * (2 ** DAC_SHIFT);
	compare_pair(MIX_W'(exp_l), 16'sd0);
	check_outputs();

	// All four active
	for (int i = 0; i < NUM_DAC_CH; i++) begin
		bytes[i] = nonzero_byte();
		bus_write(1'b1, 3'(i), bytes[i]);
	end
	settle();
	exp_l = (int'(bytes[1]) + int'(bytes[2])) * (2 ** DAC_SHIFT);
	exp_r = (int'(bytes[0]) + int'(bytes[3])) * (2 ** DAC_SHIFT);
	compare_pair(MIX_W'(exp_l), MIX_W'(exp_r));
	check_outputs();

	set_mode(DAC_OFF);
	settle();
	compare_pair(16'sd0, 16'sd0);
	finish_test("stereo_guess", errs);
endtask

task automatic test_fm_compressor();
	int errs;
	int values [9] = '{0, 1000, -1000, -1001, 16051, 20000, -20000, 32767, -32768};

	errs = error_count;
	set_mode(DAC_OFF);
	cass_i = 1'b0;
	foreach (values[i]) begin
		fm_sample_i = MIX_W'(values[i]);
		settle();
		check_outputs();
	end
	repeat (6) begin
		fm_sample_i = MIX_W'(random_bits(MIX_W));
		settle();
		check_outputs();
	end
	finish_test("fm_compressor", errs);
endtask

task automatic test_cass_saturation();
	int                      errs;
	logic signed [MIX_W-1:0] hi_l;
	logic signed [MIX_W-1:0] hi_r;

	errs = error_count;
	set_mode(DAC_DE00);
	settle();
	fm_sample_i = 16'sh7fff;
	cass_i      = 1'b1;
	for (int i = 0; i < NUM_DAC_CH; i++) begin
		bus_write(1'b0, 3'(i), 8'hff);
	end
	settle();
	compare_pair(16'sh7fff, 16'sh7fff);
	check_outputs();

	// Negative full scale with the sampler off
	set_mode(DAC_OFF);
	fm_sample_i = 16'sh8000;
	cass_i      = 1'b0;
	settle();
	compare_pair(MIX_W'(compress_ref(-32768)), MIX_W'(compress_ref(-32768)));

	cass_i = 1'b1;
	settle();
	check_outputs();
	hi_l = audio_l_o;
	hi_r = audio_r_o;
	cass_i = 1'b0;
	settle();
	compare_sample("audio_l_o cassette step", hi_l - audio_l_o, MIX_W'(CASS_LEVEL));
	compare_sample("audio_r_o cassette step", hi_r - audio_r_o, MIX_W'(CASS_LEVEL));
	finish_test("cass_saturation", errs);
endtask

/* verif/digimax_tb.sv */
`timescale 1ns/1ps

module digimax_tb import digimax_pkg::*; ();

	localparam int          CLK_PERIOD    = 100;
	localparam int          DRIVE_DELAY   = 10;
	localparam int          RESET_CYCLES  = 5;
	localparam int          SETTLE_CYCLES = 8;
	// Five tests take a few hundred cycles, the limit leaves wide margin
	localparam int          MAX_CYCLES    = 5000;
	localparam logic [31:0] LFSR_SEED     = 32'hb2c422d4;

	logic                    clk_sys;
	logic                    reset_n;
	io_bus_t                 bus_i;
	dac_mode_t               mode_i;
	logic signed [MIX_W-1:0] fm_sample_i;
	logic                    cass_i;
	logic signed [MIX_W-1:0] audio_l_o;
	logic signed [MIX_W-1:0] audio_r_o;

	// Reference state of the four channels
	logic [DAC_DATA_W-1:0] ref_level [NUM_DAC_CH];
	logic [NUM_DAC_CH-1:0] ref_active;

	logic [31:0] lfsr_state = LFSR_SEED;
	int          cycle_count = 0;
	int          error_count = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	digimax_audio_top digimax_audio_top_inst (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.bus_i       (bus_i),
		.mode_i      (mode_i),
		.fm_sample_i (fm_sample_i),
		.cass_i      (cass_i),
		.audio_l_o   (audio_l_o),
		.audio_r_o   (audio_r_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ====================
	// Random numbers
	// ====================

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int nbits);
		logic [31:0] value;

		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [DAC_DATA_W-1:0] nonzero_byte();
		logic [DAC_DATA_W-1:0] b;

		b = DAC_DATA_W'(random_bits(DAC_DATA_W));
		if (b == '0) begin
			b = 8'd1;
		end
		return b;
	endfunction

	// ====================
	// Reference model
	// ====================

	function automatic int compress_ref(input int x);
		int att;
		int v;
		int shaped;

		att = x - (x >>> 3);
		v = (att < 0) ? -att : att;
		if (v < COMP_KNEE) begin
			shaped = v * COMP_GAIN;
		end else begin
			shaped = (v - COMP_KNEE) / COMP_DIV + COMP_BASE;
		end
		return (att < 0) ? -shaped : shaped;
	endfunction

	// Mode guess from the activity flags, channel 0 is the LSB
	function automatic int dac_ref(input logic left);
		int l0;
		int l1;
		int l2;
		int l3;

		l0 = int'(ref_level[0]);
		l1 = int'(ref_level[1]);
		l2 = int'(ref_level[2]);
		l3 = int'(ref_level[3]);
		if (ref_active < 2) begin
			return 2 * l0;
		end
		if (ref_active == 2) begin
			return left ? 2 * l1 : 2 * l0;
		end
		return left ? l1 + l2 : l0 + l3;
	endfunction

	function automatic int mix_ref(input int fm_c, input int dac, input logic cass);
		int sum;

		sum = fm_c + dac * (2 ** DAC_SHIFT);
		if (cass) begin
			sum = sum + CASS_LEVEL;
		end
		if (sum > 32767) begin
			return 32767;
		end
		if (sum < -32768) begin
			return -32768;
		end
		return sum;
	endfunction

	task automatic model_write(input logic on_iof, input logic [2:0] addr,
		input logic [DAC_DATA_W-1:0] data);
		if ((mode_i == DAC_DE00 && !on_iof) || (mode_i == DAC_DF00 && on_iof)) begin
			if (!addr[2]) begin
				ref_level[addr[1:0]] = data;
				if (data != '0) begin
					ref_active[addr[1:0]] = 1'b1;
				end
			end
		end
	endtask

	// ====================
	// Drivers
	// ====================

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic settle();
		repeat (SETTLE_CYCLES) next_cycle();
	endtask

	task automatic set_mode(input dac_mode_t m);
		mode_i = m;
		// The off window clears every channel
		if (m == DAC_OFF) begin
			foreach (ref_level[i]) begin
				ref_level[i] = '0;
			end
			ref_active = '0;
		end
	endtask

	// Select high with write for one cycle, then low for one cycle
	task automatic bus_write(input logic on_iof, input logic [2:0] addr,
		input logic [DAC_DATA_W-1:0] data);
		bus_i.ioe  = ~on_iof;
		bus_i.iof  = on_iof;
		bus_i.wr   = 1'b1;
		bus_i.addr = addr;
		bus_i.data = data;
		next_cycle();
		bus_i.ioe = 1'b0;
		bus_i.iof = 1'b0;
		bus_i.wr  = 1'b0;
		next_cycle();
		model_write(on_iof, addr, data);
	endtask

	// ====================
	// Checks
	// ====================

	task automatic compare_sample(input string name, input logic signed [MIX_W-1:0] actual,
		input logic signed [MIX_W-1:0] expected);
		if (actual !== expected) begin
			$display("error: time %0t %s expected %0d actual %0d", $time, name, expected, actual);
			error_count = error_count + 1;
		end
	endtask

	task automatic compare_pair(input logic signed [MIX_W-1:0] exp_l,
		input logic signed [MIX_W-1:0] exp_r);
		compare_sample("audio_l_o", audio_l_o, exp_l);
		compare_sample("audio_r_o", audio_r_o, exp_r);
	endtask

	task automatic check_outputs();
		int fm_c;
		int exp_l;
		int exp_r;

		fm_c  = compress_ref(int'(fm_sample_i));
		exp_l = mix_ref(fm_c, dac_ref(1'b1), cass_i);
		exp_r = mix_ref(fm_c, dac_ref(1'b0), cass_i);
		compare_pair(MIX_W'(exp_l), MIX_W'(exp_r));
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed = tests_passed + 1;
			$display("test %s: ok", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	`include "digimax_tests.svh"

	initial begin
		reset_n     = 1'b0;
		bus_i       = '0;
		mode_i      = DAC_OFF;
		fm_sample_i = '0;
		cass_i      = 1'b0;
		set_mode(DAC_OFF);
		repeat (RESET_CYCLES) next_cycle();
		reset_n = 1'b1;

		test_reset_silence();
		test_mono_guess();
		test_stereo_guess();
		test_fm_compressor();
		test_cass_saturation();

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+verif
logic/digimax_pkg.sv
logic/io_strobe.sv
logic/dac_channel.sv
logic/fm_compressor.sv
logic/stereo_mixer.sv
logic/digimax_audio_top.sv
verif/digimax_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the DigiMax audio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f compile.f \
	--top-module digimax_tb \
	-o digimax_sim

out=$(./obj_dir/digimax_sim)
echo "$out"

# Exit status follows the pass message
echo "$out" | grep -qF '*** TEST PASSED ***'
